// ==== common/exu_defs.svh ====
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data and address width
`define EXU_W 32

// alu op codes
`define EXU_ALU_ADD  4'd0
`define EXU_ALU_SUB  4'd1
`define EXU_ALU_AND  4'd2
`define EXU_ALU_OR   4'd3
`define EXU_ALU_XOR  4'd4
`define EXU_ALU_SLL  4'd5
`define EXU_ALU_SRL  4'd6
`define EXU_ALU_SRA  4'd7
`define EXU_ALU_SLT  4'd8
`define EXU_ALU_SLTU 4'd9
`define EXU_ALU_SLE  4'd10
`define EXU_ALU_SLEU 4'd11

// csr func3 codes with bit 2 set for the immediate forms
`define EXU_F3_CSRRW  3'b001
`define EXU_F3_CSRRS  3'b010
`define EXU_F3_CSRRC  3'b011
`define EXU_F3_CSRRWI 3'b101
`define EXU_F3_CSRRSI 3'b110
`define EXU_F3_CSRRCI 3'b111

// machine csr addresses
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

`define EXU_CAUSE_ECALL 11

`endif

// ==== common/exu_pkg.sv ====
`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

  typedef logic [`EXU_W-1:0] word_t;
  typedef logic [`EXU_W-1:0] addr_t;
  typedef logic [31:0]       inst_t;
  typedef logic [3:0]        alu_op_t;

  // rv32e register index
  typedef logic [3:0]        reg_idx_t;

  typedef logic [11:0]       csr_addr_t;

  // busy_alu and done_mem both present a result
  typedef enum logic [1:0] {
    idle,
    busy_alu,
    wait_mem,
    done_mem
  } exu_state_t;

endpackage

`default_nettype wire

// ==== common/idu_pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface idu_pipe_if
  import exu_pkg::*;
();

  addr_t    pc;
  inst_t    inst;
  word_t    imm;
  word_t    op1;
  word_t    op2;
  // base for branch, jump and load/store targets
  addr_t    opj;
  alu_op_t  alu_op;
  reg_idx_t rd;
  logic     ren;
  logic     wen;
  logic     jen;
  logic     ben;
  logic     system;
  logic     csr_wen;
  logic     ebreak;
  logic     ecall;
  logic     mret;
  logic     speculation;

  modport idu (
    output pc, inst, imm, op1, op2, opj, alu_op, rd,
    output ren, wen, jen, ben, system, csr_wen, ebreak, ecall, mret, speculation
  );

  modport exu (
    input pc, inst, imm, op1, op2, opj, alu_op, rd,
    input ren, wen, jen, ben, system, csr_wen, ebreak, ecall, mret, speculation
  );

endinterface

`default_nettype wire

// ==== exu/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_alu
  import exu_pkg::*;
(
  input  word_t   src1_i,
  input  word_t   src2_i,
  input  alu_op_t op_i,
  output word_t   res_o
);

  logic [4:0] shamt;

  assign shamt = src2_i[4:0];

  always_comb begin
    case (op_i)
      `EXU_ALU_ADD:  res_o = src1_i + src2_i;
      `EXU_ALU_SUB:  res_o = src1_i - src2_i;
      `EXU_ALU_AND:  res_o = src1_i & src2_i;
      `EXU_ALU_OR:   res_o = src1_i | src2_i;
      `EXU_ALU_XOR:  res_o = src1_i ^ src2_i;
      `EXU_ALU_SLL:  res_o = src1_i << shamt;
      `EXU_ALU_SRL:  res_o = src1_i >> shamt;
      `EXU_ALU_SRA:  res_o = word_t'($signed(src1_i) >>> shamt);
      // compares give 1 or 0
      `EXU_ALU_SLT:  res_o = word_t'($signed(src1_i) < $signed(src2_i));
      `EXU_ALU_SLTU: res_o = word_t'(src1_i < src2_i);
      `EXU_ALU_SLE:  res_o = word_t'($signed(src1_i) <= $signed(src2_i));
      `EXU_ALU_SLEU: res_o = word_t'(src1_i <= src2_i);
      default:       res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== exu/exu_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_csr
  import exu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      wen_i,
  input  logic      ecall_i,
  input  csr_addr_t waddr_i,
  input  word_t     wdata_i,
  input  word_t     epc_i,
  input  csr_addr_t raddr_i,
  output word_t     rdata_o,
  output word_t     mepc_o,
  output word_t     mtvec_o
);

  word_t mstatus;
  word_t mtvec;
  word_t mepc;
  word_t mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wen_i) begin
        case (waddr_i)
          `EXU_CSR_MSTATUS: mstatus <= wdata_i;
          `EXU_CSR_MTVEC:   mtvec   <= wdata_i;
          `EXU_CSR_MEPC:    mepc    <= wdata_i;
          `EXU_CSR_MCAUSE:  mcause  <= wdata_i;
          default: ;
        endcase
      end
      // trap entry side port
      if (ecall_i) begin
        mcause <= word_t'(`EXU_CAUSE_ECALL);
        mepc   <= epc_i;
      end
    end
  end

  always_comb begin
    case (raddr_i)
      `EXU_CSR_MSTATUS: rdata_o = mstatus;
      `EXU_CSR_MTVEC:   rdata_o = mtvec;
      `EXU_CSR_MEPC:    rdata_o = mepc;
      `EXU_CSR_MCAUSE:  rdata_o = mcause;
      default:          rdata_o = '0;
    endcase
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  // the stage must never let a csr write collide with the trap update
  assert property (@(posedge clk) disable iff (rst)
    !(wen_i && ecall_i &&
      (waddr_i == `EXU_CSR_MEPC || waddr_i == `EXU_CSR_MCAUSE)));

endmodule

`default_nettype wire

// ==== exu/exu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_stage
  import exu_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  idu_pipe_if.exu      idu,
  input  logic         prev_valid_i,
  input  logic         next_ready_i,
  output logic         valid_o,
  output logic         ready_o,
  output logic         lsu_avalid_o,
  output word_t        lsu_wdata_o,
  input  word_t        lsu_rdata_i,
  input  logic         lsu_rvalid_i,
  input  logic         lsu_wready_i,
  output addr_t        pc_o,
  output inst_t        inst_o,
  output reg_idx_t     rd_o,
  output addr_t        rwaddr_o,
  output logic         ren_o,
  output logic         wen_o,
  output word_t        reg_wdata_o,
  output addr_t        npc_o,
  output logic         use_npc_o,
  output logic         ebreak_o,
  output logic         speculation_o
);

  exu_state_t state;
  word_t      imm_q, op1_q, op2_q, mem_rdata_q;
  addr_t      opj_q;
  alu_op_t    alu_op_q;
  logic       jen_q, ben_q, system_q, csr_wen_q, ecall_q, mret_q;
  word_t      alu_res, csr_rdata, csr_wdata, mepc, mtvec;
  csr_addr_t  csr_addr;
  logic [2:0] func3;
  logic       take, hs, resp;

  assign take = prev_valid_i & ready_o;
  assign hs   = valid_o & next_ready_i;
  assign resp = (ren_o & lsu_rvalid_i) | (wen_o & lsu_wready_i);

  assign valid_o      = (state == busy_alu) | (state == done_mem);
  assign lsu_avalid_o = (state == wait_mem);
  assign ready_o      = next_ready_i & (state != wait_mem);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        wait_mem: if (resp) state <= done_mem;
        default: begin
          if (take) begin
            state <= (idu.ren | idu.wen) ? wait_mem : busy_alu;
          end else if (hs) begin
            state <= idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      pc_o          <= idu.pc;
      inst_o        <= idu.inst;
      imm_q         <= idu.imm;
      op1_q         <= idu.op1;
      op2_q         <= idu.op2;
      opj_q         <= idu.opj;
      alu_op_q      <= idu.alu_op;
      rd_o          <= idu.rd;
      ren_o         <= idu.ren;
      wen_o         <= idu.wen;
      jen_q         <= idu.jen;
      ben_q         <= idu.ben;
      system_q      <= idu.system;
      csr_wen_q     <= idu.csr_wen;
      ebreak_o      <= idu.ebreak;
      ecall_q       <= idu.ecall;
      mret_q        <= idu.mret;
      speculation_o <= idu.speculation;
    end
    if (state == wait_mem && ren_o && lsu_rvalid_i) begin
      mem_rdata_q <= lsu_rdata_i;
    end
  end

  assign rwaddr_o    = opj_q + imm_q;
  assign lsu_wdata_o = op2_q;
  assign func3       = inst_o[14:12];
  // mret targets mstatus and csr ops carry the address in imm
  assign csr_addr    = mret_q ? `EXU_CSR_MSTATUS : imm_q[11:0];

  exu_alu u_alu (
    .src1_i (op1_q),
    .src2_i (op2_q),
    .op_i   (alu_op_q),
    .res_o  (alu_res)
  );

  always_comb begin
    csr_wdata = csr_rdata;
    if (mret_q) begin
      csr_wdata[3] = csr_rdata[7];
      csr_wdata[7] = 1'b1;
    end else begin
      case (func3)
        `EXU_F3_CSRRW, `EXU_F3_CSRRWI: csr_wdata = op1_q;
        `EXU_F3_CSRRS, `EXU_F3_CSRRSI: csr_wdata = csr_rdata | op1_q;
        `EXU_F3_CSRRC, `EXU_F3_CSRRCI: csr_wdata = csr_rdata & ~op1_q;
        default:                       csr_wdata = csr_rdata;
      endcase
    end
  end

  // csr state moves only when the result is accepted
  exu_csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .wen_i   (hs & system_q & (csr_wen_q | mret_q)),
    .ecall_i (hs & ecall_q),
    .waddr_i (csr_addr),
    .wdata_i (csr_wdata),
    .epc_i   (pc_o),
    .raddr_i (csr_addr),
    .rdata_o (csr_rdata),
    .mepc_o  (mepc),
    .mtvec_o (mtvec)
  );

  always_comb begin
    if (rd_o == '0) begin
      reg_wdata_o = '0;
    end else if (ren_o) begin
      reg_wdata_o = mem_rdata_q;
    end else if (system_q) begin
      reg_wdata_o = csr_rdata;
    end else begin
      reg_wdata_o = alu_res;
    end
  end

  always_comb begin
    if (ben_q) begin
      case (alu_op_q)
        `EXU_ALU_SUB: use_npc_o = ~|alu_res;
        `EXU_ALU_XOR, `EXU_ALU_SLT, `EXU_ALU_SLTU,
        `EXU_ALU_SLE, `EXU_ALU_SLEU: use_npc_o = |alu_res;
        default: use_npc_o = 1'b0;
      endcase
    end else begin
      use_npc_o = jen_q | ecall_q | mret_q;
    end
  end

  assign npc_o = ecall_q ? mtvec : (mret_q ? mepc : rwaddr_o);

  assert property (@(posedge clk) disable iff (rst)
    take |-> !(idu.ren && idu.wen));

  // request, address and data hold until the bus answers
  assert property (@(posedge clk) disable iff (rst)
    lsu_avalid_o && !resp |=>
      lsu_avalid_o && $stable(rwaddr_o) && $stable(lsu_wdata_o));

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top
  import exu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  addr_t    pc_i,
  input  inst_t    inst_i,
  input  word_t    imm_i,
  input  word_t    op1_i,
  input  word_t    op2_i,
  input  addr_t    opj_i,
  input  alu_op_t  alu_op_i,
  input  reg_idx_t rd_i,
  input  logic     ren_i,
  input  logic     wen_i,
  input  logic     jen_i,
  input  logic     ben_i,
  input  logic     system_i,
  input  logic     csr_wen_i,
  input  logic     ebreak_i,
  input  logic     ecall_i,
  input  logic     mret_i,
  input  logic     speculation_i,
  input  logic     prev_valid_i,
  input  logic     next_ready_i,
  output logic     valid_o,
  output logic     ready_o,
  output logic     lsu_avalid_o,
  output word_t    lsu_wdata_o,
  input  word_t    lsu_rdata_i,
  input  logic     lsu_rvalid_i,
  input  logic     lsu_wready_i,
  output addr_t    pc_o,
  output inst_t    inst_o,
  output reg_idx_t rd_o,
  output addr_t    rwaddr_o,
  output logic     ren_o,
  output logic     wen_o,
  output word_t    reg_wdata_o,
  output addr_t    npc_o,
  output logic     use_npc_o,
  output logic     ebreak_o,
  output logic     speculation_o
);

  idu_pipe_if pipe ();

  // decoder side of the bundle
  assign pipe.pc          = pc_i;
  assign pipe.inst        = inst_i;
  assign pipe.imm         = imm_i;
  assign pipe.op1         = op1_i;
  assign pipe.op2         = op2_i;
  assign pipe.opj         = opj_i;
  assign pipe.alu_op      = alu_op_i;
  assign pipe.rd          = rd_i;
  assign pipe.ren         = ren_i;
  assign pipe.wen         = wen_i;
  assign pipe.jen         = jen_i;
  assign pipe.ben         = ben_i;
  assign pipe.system      = system_i;
  assign pipe.csr_wen     = csr_wen_i;
  assign pipe.ebreak      = ebreak_i;
  assign pipe.ecall       = ecall_i;
  assign pipe.mret        = mret_i;
  assign pipe.speculation = speculation_i;

  exu_stage u_stage (
    .clk           (clk),
    .rst           (rst),
    .idu           (pipe.exu),
    .prev_valid_i  (prev_valid_i),
    .next_ready_i  (next_ready_i),
    .valid_o       (valid_o),
    .ready_o       (ready_o),
    .lsu_avalid_o  (lsu_avalid_o),
    .lsu_wdata_o   (lsu_wdata_o),
    .lsu_rdata_i   (lsu_rdata_i),
    .lsu_rvalid_i  (lsu_rvalid_i),
    .lsu_wready_i  (lsu_wready_i),
    .pc_o          (pc_o),
    .inst_o        (inst_o),
    .rd_o          (rd_o),
    .rwaddr_o      (rwaddr_o),
    .ren_o         (ren_o),
    .wen_o         (wen_o),
    .reg_wdata_o   (reg_wdata_o),
    .npc_o         (npc_o),
    .use_npc_o     (use_npc_o),
    .ebreak_o      (ebreak_o),
    .speculation_o (speculation_o)
  );

endmodule

`default_nettype wire

// ==== verif/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_tb
  import exu_pkg::*;
();

  localparam logic [2:0] K_ALU   = 3'd0;
  localparam logic [2:0] K_BR    = 3'd1;
  localparam logic [2:0] K_JAL   = 3'd2;
  localparam logic [2:0] K_LD    = 3'd3;
  localparam logic [2:0] K_ST    = 3'd4;
  localparam logic [2:0] K_CSR   = 3'd5;
  localparam logic [2:0] K_ECALL = 3'd6;
  localparam logic [2:0] K_MRET  = 3'd7;

  // code is the alu op or the csr func3
  typedef struct packed {
    logic [2:0] kind;
    logic [3:0] code;
    word_t      a;
    word_t      b;
    word_t      d;
    reg_idx_t   rd;
    word_t      exp_res;
    logic       exp_use;
    addr_t      exp_npc;
    addr_t      pc;
  } entry_t;

  logic     clk = 1'b0;
  logic     rst;
  addr_t    pc_i;
  inst_t    inst_i;
  word_t    imm_i;
  word_t    op1_i;
  word_t    op2_i;
  addr_t    opj_i;
  alu_op_t  alu_op_i;
  reg_idx_t rd_i;
  logic     ren_i;
  logic     wen_i;
  logic     jen_i;
  logic     ben_i;
  logic     system_i;
  logic     csr_wen_i;
  logic     ebreak_i;
  logic     ecall_i;
  logic     mret_i;
  logic     speculation_i;
  logic     prev_valid_i;
  logic     next_ready_i;
  logic     valid_o;
  logic     ready_o;
  logic     lsu_avalid_o;
  word_t    lsu_wdata_o;
  word_t    lsu_rdata_i;
  logic     lsu_rvalid_i;
  logic     lsu_wready_i;
  addr_t    pc_o;
  inst_t    inst_o;
  reg_idx_t rd_o;
  addr_t    rwaddr_o;
  logic     ren_o;
  logic     wen_o;
  word_t    reg_wdata_o;
  addr_t    npc_o;
  logic     use_npc_o;
  logic     ebreak_o;
  logic     speculation_o;

  entry_t      tbl[$];
  int          pending[$];
  word_t       mem_model [addr_t];
  logic [31:0] lfsr = 32'h7629_9e20;
  int          errors = 0;
  int          cycles = 0;
  int          limit;
  int          issued = 0;
  int          hs_count = 0;
  logic        held = 1'b0;
  logic        timed_out;
  logic        responding = 1'b0;
  logic        mem_busy = 1'b0;
  logic [1:0]  mem_delay;
  word_t       snap_wdata;
  addr_t       snap_npc;
  addr_t       snap_pc;
  addr_t       snap_rwaddr;
  logic        snap_use;

  exu_top dut_i (.*);

  always #50 clk = ~clk;

  function automatic logic next_rand_bit();
    logic lsb;
    lsb = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) lfsr = lfsr ^ 32'h8020_0003;
    return lsb;
  endfunction

  // untouched memory reads back a pattern of its address
  function automatic word_t fill_word(input addr_t addr);
    return addr ^ 32'hc3a5_5a3c;
  endfunction

  // r-type encoding with func3 from the code, system opcode for csr and traps
  function automatic inst_t inst_of(input entry_t e);
    inst_t inst;
    inst = {17'h0, e.code[2:0], 5'h0, 7'h33};
    if (e.kind inside {K_CSR, K_ECALL, K_MRET}) inst[6:0] = 7'h73;
    return inst;
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(input string what, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input bit got, input bit exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input logic [2:0] kind, input logic [3:0] code, input word_t a,
                           input word_t b, input word_t d, input reg_idx_t rd,
                           input word_t exp_res, input logic exp_use, input addr_t exp_npc);
    entry_t e;
    e.kind    = kind;
    e.code    = code;
    e.a       = a;
    e.b       = b;
    e.d       = d;
    e.rd      = rd;
    e.exp_res = exp_res;
    e.exp_use = exp_use;
    e.exp_npc = exp_npc;
    e.pc      = 32'h100 + 4 * tbl.size();
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // alu ops with the last one writing rd zero
    add_entry(K_ALU, `EXU_ALU_ADD, 32'd5, 32'd7, 32'h0, 4'd1, 32'd12, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SUB, 32'd3, 32'd5, 32'h0, 4'd2, 32'hffff_fffe, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_AND, 32'hff00, 32'h0ff0, 32'h0, 4'd3, 32'h0f00, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_OR, 32'h00f0, 32'h0f00, 32'h0, 4'd3, 32'h0ff0, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_XOR, 32'hff, 32'h0f, 32'h0, 4'd4, 32'hf0, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SLL, 32'd1, 32'd35, 32'h0, 4'd5, 32'd8, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SRL, 32'h8000_0000, 32'd4, 32'h0, 4'd6, 32'h0800_0000, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SRA, 32'h8000_0000, 32'd4, 32'h0, 4'd7, 32'hf800_0000, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SLT, 32'hffff_ffff, 32'd1, 32'h0, 4'd8, 32'd1, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SLTU, 32'hffff_ffff, 32'd1, 32'h0, 4'd9, 32'd0, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SLE, 32'd5, 32'd5, 32'h0, 4'd10, 32'd1, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_SLEU, 32'd6, 32'd5, 32'h0, 4'd11, 32'd0, 1'b0, 32'h0);
    add_entry(K_ALU, `EXU_ALU_ADD, 32'd5, 32'd7, 32'h0, 4'd0, 32'd0, 1'b0, 32'h0);
    // branches from pc 0x134 on and then a jump
    add_entry(K_BR, `EXU_ALU_SUB, 32'd9, 32'd9, 32'h40, 4'd0, 32'd0, 1'b1, 32'h174);
    add_entry(K_BR, `EXU_ALU_SUB, 32'd9, 32'd8, 32'h40, 4'd0, 32'd0, 1'b0, 32'h178);
    add_entry(K_BR, `EXU_ALU_XOR, 32'd1, 32'd2, 32'h20, 4'd0, 32'd0, 1'b1, 32'h15c);
    add_entry(K_BR, `EXU_ALU_SLT, 32'hffff_fffe, 32'd1, 32'hffff_fff8, 4'd0, 32'd0, 1'b1, 32'h138);
    add_entry(K_BR, `EXU_ALU_SLTU, 32'd5, 32'd3, 32'h10, 4'd0, 32'd0, 1'b0, 32'h154);
    add_entry(K_BR, `EXU_ALU_SLEU, 32'd3, 32'd3, 32'h8, 4'd0, 32'd0, 1'b1, 32'h150);
    add_entry(K_JAL, `EXU_ALU_ADD, 32'h0, 32'h0, 32'h100, 4'd1, 32'h150, 1'b1, 32'h24c);
    // a store, its load back and a load of untouched memory
    add_entry(K_ST, `EXU_ALU_ADD, 32'h2000, 32'hcafe_f00d, 32'h10, 4'd0, 32'd0, 1'b0, 32'h2010);
    add_entry(K_LD, `EXU_ALU_ADD, 32'h2000, 32'h0, 32'h10, 4'd5, 32'hcafe_f00d, 1'b0, 32'h2010);
    add_entry(K_LD, `EXU_ALU_ADD, 32'h3000, 32'h0, 32'h4, 4'd6, 32'hc3a5_6a38, 1'b0, 32'h3004);
    add_entry(K_LD, `EXU_ALU_ADD, 32'h2000, 32'h0, 32'h10, 4'd0, 32'd0, 1'b0, 32'h2010);
    // csr ops return the old value
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRW}, 32'h8000, 32'h0, 32'h305, 4'd7, 32'h0, 1'b0, 32'h305);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRS}, 32'h4, 32'h0, 32'h305, 4'd7, 32'h8000, 1'b0, 32'h305);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRC}, 32'h8000, 32'h0, 32'h305, 4'd7, 32'h8004, 1'b0, 32'h305);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRS}, 32'h0, 32'h0, 32'h305, 4'd8, 32'h4, 1'b0, 32'h305);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRWI}, 32'h88, 32'h0, 32'h300, 4'd1, 32'h0, 1'b0, 32'h300);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRCI}, 32'h08, 32'h0, 32'h300, 4'd1, 32'h88, 1'b0, 32'h300);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRSI}, 32'h0, 32'h0, 32'h300, 4'd1, 32'h80, 1'b0, 32'h300);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRW}, 32'h800, 32'h0, 32'h305, 4'd0, 32'h0, 1'b0, 32'h305);
    // ecall at pc 0x180 traps to mtvec
    add_entry(K_ECALL, 4'd0, 32'h0, 32'h0, 32'h0, 4'd0, 32'h0, 1'b1, 32'h800);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRS}, 32'h0, 32'h0, 32'h342, 4'd2, 32'd11, 1'b0, 32'h342);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRS}, 32'h0, 32'h0, 32'h341, 4'd3, 32'h180, 1'b0, 32'h341);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRW}, 32'h400, 32'h0, 32'h341, 4'd0, 32'h0, 1'b0, 32'h341);
    // mret sets mstatus bit 3 from bit 7
    add_entry(K_MRET, 4'd0, 32'h0, 32'h0, 32'h0, 4'd0, 32'h0, 1'b1, 32'h400);
    add_entry(K_CSR, {1'b0, `EXU_F3_CSRRS}, 32'h0, 32'h0, 32'h300, 4'd4, 32'h88, 1'b0, 32'h300);
  endtask

  task automatic clear_inputs();
    pc_i          = '0;
    inst_i        = '0;
    imm_i         = '0;
    op1_i         = '0;
    op2_i         = '0;
    opj_i         = '0;
    alu_op_i      = '0;
    rd_i          = '0;
    ren_i         = 1'b0;
    wen_i         = 1'b0;
    jen_i         = 1'b0;
    ben_i         = 1'b0;
    system_i      = 1'b0;
    csr_wen_i     = 1'b0;
    ebreak_i      = 1'b0;
    ecall_i       = 1'b0;
    mret_i        = 1'b0;
    speculation_i = 1'b0;
    prev_valid_i  = 1'b0;
    next_ready_i  = 1'b0;
    lsu_rdata_i   = '0;
    lsu_rvalid_i  = 1'b0;
    lsu_wready_i  = 1'b0;
  endtask

  task automatic drive_entry(input entry_t e);
    pc_i          = e.pc;
    inst_i        = inst_of(e);
    imm_i         = e.d;
    op1_i         = e.a;
    op2_i         = e.b;
    opj_i         = '0;
    alu_op_i      = e.code;
    rd_i          = e.rd;
    ren_i         = 1'b0;
    wen_i         = 1'b0;
    jen_i         = 1'b0;
    ben_i         = 1'b0;
    system_i      = 1'b0;
    csr_wen_i     = 1'b0;
    ecall_i       = 1'b0;
    mret_i        = 1'b0;
    speculation_i = e.pc[2];
    ebreak_i      = e.pc[3];
    case (e.kind)
      K_BR: begin
        ben_i = 1'b1;
        opj_i = e.pc;
      end
      K_JAL: begin
        jen_i = 1'b1;
        opj_i = e.pc;
        op1_i = e.pc;
        op2_i = 32'd4;
      end
      K_LD: begin
        ren_i = 1'b1;
        opj_i = e.a;
      end
      K_ST: begin
        wen_i = 1'b1;
        opj_i = e.a;
      end
      K_CSR: begin
        system_i  = 1'b1;
        csr_wen_i = 1'b1;
      end
      K_ECALL: begin
        system_i = 1'b1;
        ecall_i  = 1'b1;
      end
      K_MRET: begin
        system_i = 1'b1;
        mret_i   = 1'b1;
      end
      default: ;
    endcase
  endtask

  // bus slave with a random wait of 0 to 3 cycles
  task automatic serve_memory();
    entry_t e;
    if (responding) begin
      lsu_rvalid_i = 1'b0;
      lsu_wready_i = 1'b0;
      responding   = 1'b0;
    end else if (lsu_avalid_o) begin
      e = tbl[pending[0]];
      if (!mem_busy) begin
        check_addr("rwaddr_o", rwaddr_o, e.exp_npc);
        if (wen_o) check_word("lsu_wdata_o", lsu_wdata_o, e.b);
        mem_delay[1] = next_rand_bit();
        mem_delay[0] = next_rand_bit();
        mem_busy     = 1'b1;
      end
      if (mem_delay == 2'd0) begin
        if (ren_o) begin
          if (mem_model.exists(rwaddr_o)) begin
            lsu_rdata_i = mem_model[rwaddr_o];
          end else begin
            lsu_rdata_i = fill_word(rwaddr_o);
          end
          lsu_rvalid_i = 1'b1;
        end else begin
          mem_model[rwaddr_o] = lsu_wdata_o;
          lsu_wready_i = 1'b1;
        end
        mem_busy   = 1'b0;
        responding = 1'b1;
      end else begin
        mem_delay = mem_delay - 2'd1;
      end
    end
  endtask

  task automatic score_result(input int idx);
    entry_t e;
    e = tbl[idx];
    check_word($sformatf("entry %0d reg_wdata_o", idx), reg_wdata_o, e.exp_res);
    check_flag($sformatf("entry %0d use_npc_o", idx), use_npc_o, e.exp_use);
    check_addr($sformatf("entry %0d npc_o", idx), npc_o, e.exp_npc);
    check_addr($sformatf("entry %0d pc_o", idx), pc_o, e.pc);
    check_inst($sformatf("entry %0d inst_o", idx), inst_o, inst_of(e));
    check_idx($sformatf("entry %0d rd_o", idx), rd_o, e.rd);
    check_flag($sformatf("entry %0d ren_o", idx), ren_o, e.kind == K_LD);
    check_flag($sformatf("entry %0d wen_o", idx), wen_o, e.kind == K_ST);
    check_flag($sformatf("entry %0d ebreak_o", idx), ebreak_o, e.pc[3]);
    check_flag($sformatf("entry %0d speculation_o", idx), speculation_o, e.pc[2]);
  endtask

  task automatic confirm_hold();
    check_flag("valid_o under back-pressure", valid_o, 1'b1);
    check_word("reg_wdata_o under back-pressure", reg_wdata_o, snap_wdata);
    check_addr("npc_o under back-pressure", npc_o, snap_npc);
    check_addr("pc_o under back-pressure", pc_o, snap_pc);
    check_addr("rwaddr_o under back-pressure", rwaddr_o, snap_rwaddr);
    check_flag("use_npc_o under back-pressure", use_npc_o, snap_use);
  endtask

  task automatic step_cycle();
    logic take;
    logic hs;
    int   idx;
    @(negedge clk);
    cycles++;
    if (held) confirm_hold();
    if (lsu_avalid_o) check_flag("ready_o during memory access", ready_o, 1'b0);
    serve_memory();
    // downstream ready about three cycles in four
    next_ready_i = next_rand_bit();
    next_ready_i = next_ready_i | next_rand_bit();
    if (issued < tbl.size()) begin
      drive_entry(tbl[issued]);
      // upstream leaves a gap about one cycle in four
      prev_valid_i = next_rand_bit();
      prev_valid_i = prev_valid_i | next_rand_bit();
    end else begin
      prev_valid_i = 1'b0;
    end
    #1;
    take = prev_valid_i & ready_o;
    hs   = valid_o & next_ready_i;
    if (hs && pending.size() == 0) begin
      errors++;
      $display("valid_o handshake at %0t ns with no instruction in flight", $time);
    end else if (hs) begin
      idx = pending.pop_front();
      score_result(idx);
      hs_count++;
    end
    if (take) begin
      pending.push_back(issued);
      issued++;
    end
    held = valid_o & ~next_ready_i;
    if (held) begin
      snap_wdata  = reg_wdata_o;
      snap_npc    = npc_o;
      snap_pc     = pc_o;
      snap_rwaddr = rwaddr_o;
      snap_use    = use_npc_o;
    end
  endtask

  initial begin
    clear_inputs();
    rst = 1'b1;
    build_table();
    limit = tbl.size() * 8 + 50;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (hs_count < tbl.size() && cycles < limit) begin
      step_cycle();
    end
    timed_out = (hs_count < tbl.size());
    if (timed_out) begin
      $display("timeout after %0d cycles, only %0d of %0d instructions completed",
               cycles, hs_count, tbl.size());
    end
    $display("errors: %0d, handshakes: %0d of %0d, cycles: %0d",
             errors, hs_count, tbl.size(), cycles);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/exu_pkg.sv
common/idu_pipe_if.sv
exu/exu_alu.sv
exu/exu_csr.sv
exu/exu_stage.sv
rtl/exu_top.sv
verif/exu_tb.sv

// ==== Makefile ====
TOP := exu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -f src.f --top-module exu_top

clean:
	rm -rf obj_dir
